//--- hdl/fpu_cmp_pkg.sv
package fpu_cmp_pkg;

  // compare unit opcodes
  typedef enum logic [2:0] {
    OP_EQ  = 3'd0,
    OP_LT  = 3'd1,
    OP_LE  = 3'd2,
    OP_MIN = 3'd3,
    OP_MAX = 3'd4
  } cmp_op_e;

  // control half of a request, follows the data down the pipe
  typedef struct packed {
    logic    valid;
    cmp_op_e op;
  } cmp_req_s;

  // per-lane comparison results and exception bits
  typedef struct packed {
    logic eq;
    logic lt;
    logic le;
    logic lt_le_invalid;
    logic eq_invalid;
    logic min_max_invalid;
  } lane_flags_s;

endpackage

//--- hdl/fpu_classify.sv
`timescale 1ns/1ns

module fpu_classify
  #(parameter e_p = 8
    , parameter m_p = 23
  )
  (
    input  logic [e_p+m_p:0] a_i
    , output logic           zero_o
    , output logic           infty_o
    , output logic           nan_o
    , output logic           sig_nan_o
    , output logic           sign_o
  );

  logic [e_p-1:0] exp;
  logic [m_p-1:0] man;
  logic           exp_ones;
  logic           exp_zero;
  logic           man_zero;

  assign exp = a_i[e_p+m_p-1:m_p];
  assign man = a_i[m_p-1:0];

  assign exp_ones = &exp;
  assign exp_zero = ~|exp;
  assign man_zero = ~|man;

  // denormals are not flagged, they order correctly by bit pattern
  assign zero_o  = exp_zero & man_zero;
  assign infty_o = exp_ones & man_zero;
  assign nan_o   = exp_ones & ~man_zero;

  // quiet bit is the top mantissa bit
  assign sig_nan_o = nan_o & ~man[m_p-1];

  assign sign_o = a_i[e_p+m_p];

endmodule

//--- hdl/fpu_cmp_issue.sv
`timescale 1ns/1ns

module fpu_cmp_issue
  #(parameter lanes_p = 4
    , parameter e_p = 8
    , parameter m_p = 23
  )
  (
    input  logic                                clk_i
    , input  logic                              arst_n_i
    , input  logic                              valid_i
    , input  fpu_cmp_pkg::cmp_op_e              op_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]    a_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]    b_i
    , output fpu_cmp_pkg::cmp_req_s             req_o
    , output logic [lanes_p*(e_p+m_p+1)-1:0]    a_o
    , output logic [lanes_p*(e_p+m_p+1)-1:0]    b_o
  );

  localparam int vec_w_lp = lanes_p*(e_p+m_p+1);

  logic                 valid_q;
  fpu_cmp_pkg::cmp_op_e op_q;
  logic [vec_w_lp-1:0]  a_q;
  logic [vec_w_lp-1:0]  b_q;

  // valid follows the strobe every cycle, opcode only on a new request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      op_q    <= fpu_cmp_pkg::OP_EQ;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        op_q <= op_i;
      end
    end
  end

  // operand vectors hold between requests
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  assign req_o.valid = valid_q;
  assign req_o.op    = op_q;

  // one copy fans out to every lane
  assign a_o = a_q;
  assign b_o = b_q;

endmodule

//--- hdl/fpu_cmp_lane.sv
`timescale 1ns/1ns

module fpu_cmp_lane
  #(parameter e_p = 8
    , parameter m_p = 23
  )
  (
    input  logic                        clk_i
    , input  logic                      arst_n_i
    , input  fpu_cmp_pkg::cmp_req_s     req_i
    , input  logic [e_p+m_p:0]          a_i
    , input  logic [e_p+m_p:0]          b_i
    , output fpu_cmp_pkg::cmp_req_s     req_o
    , output fpu_cmp_pkg::lane_flags_s  flags_o
    , output logic [e_p+m_p:0]          min_o
    , output logic [e_p+m_p:0]          max_o
  );

  // canonical quiet NaN: positive, exponent all ones, only quiet bit set
  localparam logic [e_p+m_p:0] qnan_lp = {1'b0, {e_p{1'b1}}, 1'b1, {(m_p-1){1'b0}}};

  logic a_zero, a_nan, a_sig_nan, a_sign;
  logic b_zero, b_nan, b_sig_nan, b_sign;
  logic mag_lt;
  logic same_bits;

  logic eq_c, lt_c, le_c;
  logic lt_le_inv_c, eq_inv_c, mm_inv_c;
  logic [e_p+m_p:0] min_c, max_c;

  fpu_cmp_pkg::cmp_req_s    req_q;
  fpu_cmp_pkg::lane_flags_s flags_q;
  logic [e_p+m_p:0]         min_q, max_q;

  fpu_classify #(.e_p(e_p), .m_p(m_p)) i_class_a (
    .a_i       (a_i),
    .zero_o    (a_zero),
    .infty_o   (),
    .nan_o     (a_nan),
    .sig_nan_o (a_sig_nan),
    .sign_o    (a_sign)
  );

  fpu_classify #(.e_p(e_p), .m_p(m_p)) i_class_b (
    .a_i       (b_i),
    .zero_o    (b_zero),
    .infty_o   (),
    .nan_o     (b_nan),
    .sig_nan_o (b_sig_nan),
    .sign_o    (b_sign)
  );

  // magnitude order of everything below the sign bit
  assign mag_lt    = a_i[e_p+m_p-1:0] < b_i[e_p+m_p-1:0];
  assign same_bits = (a_i == b_i);

  always_comb begin
    eq_c        = 1'b0;
    lt_c        = 1'b0;
    le_c        = 1'b0;
    lt_le_inv_c = 1'b0;
    eq_inv_c    = 1'b0;
    if (a_nan | b_nan) begin
      // unordered, eq only complains about signaling inputs
      lt_le_inv_c = 1'b1;
      eq_inv_c    = a_sig_nan | b_sig_nan;
    end else if (a_zero & b_zero) begin
      // +0 and -0 are equal
      eq_c = 1'b1;
      le_c = 1'b1;
    end else begin
      eq_c = same_bits;
      case ({a_sign, b_sign})
        2'b00: begin
          lt_c = mag_lt;
          le_c = mag_lt | same_bits;
        end
        2'b10: begin
          lt_c = 1'b1;
          le_c = 1'b1;
        end
        2'b11: begin
          // both negative, larger magnitude is smaller
          lt_c = ~mag_lt & ~same_bits;
          le_c = ~mag_lt | same_bits;
        end
        default: begin
          lt_c = 1'b0;
          le_c = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    mm_inv_c = 1'b0;
    if (a_sig_nan | b_sig_nan) begin
      min_c    = qnan_lp;
      max_c    = qnan_lp;
      mm_inv_c = 1'b1;
    end else if (a_nan & b_nan) begin
      min_c = qnan_lp;
      max_c = qnan_lp;
    end else if (a_nan) begin
      // single quiet NaN loses to the number
      min_c = b_i;
      max_c = b_i;
    end else if (b_nan) begin
      min_c = a_i;
      max_c = a_i;
    end else if (a_zero & b_zero) begin
      min_c = '0;
      max_c = '0;
    end else if (lt_c) begin
      min_c = a_i;
      max_c = b_i;
    end else begin
      min_c = b_i;
      max_c = a_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= '0;
    end else begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    flags_q.eq              <= eq_c;
    flags_q.lt              <= lt_c;
    flags_q.le              <= le_c;
    flags_q.lt_le_invalid   <= lt_le_inv_c;
    flags_q.eq_invalid      <= eq_inv_c;
    flags_q.min_max_invalid <= mm_inv_c;
    min_q                   <= min_c;
    max_q                   <= max_c;
  end

  assign req_o   = req_q;
  assign flags_o = flags_q;
  assign min_o   = min_q;
  assign max_o   = max_q;

endmodule

//--- hdl/fpu_cmp_collect.sv
`timescale 1ns/1ns

module fpu_cmp_collect
  #(parameter lanes_p = 4
    , parameter e_p = 8
    , parameter m_p = 23
  )
  (
    input  logic                                          clk_i
    , input  logic                                        arst_n_i
    , input  fpu_cmp_pkg::cmp_req_s                       req_i
    , input  fpu_cmp_pkg::lane_flags_s [lanes_p-1:0]      flags_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]              min_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]              max_i
    , output logic                                        valid_o
    , output logic [lanes_p*(e_p+m_p+1)-1:0]              res_o
    , output logic [lanes_p-1:0]                          invalid_o
    , output logic                                        invalid_any_o
  );

  localparam int w_lp = e_p+m_p+1;

  logic [lanes_p*w_lp-1:0] res_d;
  logic [lanes_p-1:0]      inv_d;

  logic                    valid_q;
  logic [lanes_p*w_lp-1:0] res_q;
  logic [lanes_p-1:0]      inv_q;
  logic                    inv_any_q;

  // per lane result mux, compares land in bit 0
  always_comb begin
    for (int k = 0; k < lanes_p; k++) begin
      case (req_i.op)
        fpu_cmp_pkg::OP_EQ: begin
          res_d[k*w_lp +: w_lp] = {{(w_lp-1){1'b0}}, flags_i[k].eq};
          inv_d[k]              = flags_i[k].eq_invalid;
        end
        fpu_cmp_pkg::OP_LT: begin
          res_d[k*w_lp +: w_lp] = {{(w_lp-1){1'b0}}, flags_i[k].lt};
          inv_d[k]              = flags_i[k].lt_le_invalid;
        end
        fpu_cmp_pkg::OP_LE: begin
          res_d[k*w_lp +: w_lp] = {{(w_lp-1){1'b0}}, flags_i[k].le};
          inv_d[k]              = flags_i[k].lt_le_invalid;
        end
        fpu_cmp_pkg::OP_MIN: begin
          res_d[k*w_lp +: w_lp] = min_i[k*w_lp +: w_lp];
          inv_d[k]              = flags_i[k].min_max_invalid;
        end
        fpu_cmp_pkg::OP_MAX: begin
          res_d[k*w_lp +: w_lp] = max_i[k*w_lp +: w_lp];
          inv_d[k]              = flags_i[k].min_max_invalid;
        end
        default: begin
          res_d[k*w_lp +: w_lp] = '0;
          inv_d[k]              = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      res_q     <= '0;
      inv_q     <= '0;
      inv_any_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      // flags only live for the output cycle
      inv_q     <= req_i.valid ? inv_d : '0;
      inv_any_q <= req_i.valid & (|inv_d);
      if (req_i.valid) begin
        res_q <= res_d;
      end
    end
  end

  assign valid_o       = valid_q;
  assign res_o         = res_q;
  assign invalid_o     = inv_q;
  assign invalid_any_o = inv_any_q;

endmodule

//--- hdl/fpu_vec_cmp.sv
`timescale 1ns/1ns

module fpu_vec_cmp
  #(parameter lanes_p = 4
    , parameter e_p = 8
    , parameter m_p = 23
  )
  (
    input  logic                                clk_i
    , input  logic                              arst_n_i
    , input  logic                              valid_i
    , input  fpu_cmp_pkg::cmp_op_e              op_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]    a_i
    , input  logic [lanes_p*(e_p+m_p+1)-1:0]    b_i
    , output logic                              valid_o
    , output logic [lanes_p*(e_p+m_p+1)-1:0]    res_o
    , output logic [lanes_p-1:0]                invalid_o
    , output logic                              invalid_any_o
  );

  localparam int w_lp = e_p+m_p+1;

  fpu_cmp_pkg::cmp_req_s                  issue_req;
  fpu_cmp_pkg::cmp_req_s                  lane_req;
  logic [lanes_p*w_lp-1:0]                issue_a, issue_b;
  fpu_cmp_pkg::lane_flags_s [lanes_p-1:0] lane_flags;
  logic [lanes_p*w_lp-1:0]                lane_min, lane_max;

  fpu_cmp_issue #(.lanes_p(lanes_p), .e_p(e_p), .m_p(m_p)) i_issue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .req_o    (issue_req),
    .a_o      (issue_a),
    .b_o      (issue_b)
  );

  // lane 0 carries the request on to the collector
  for (genvar g = 0; g < lanes_p; g++) begin : g_lane
    if (g == 0) begin : g_head
      fpu_cmp_lane #(.e_p(e_p), .m_p(m_p)) i_lane (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (issue_req),
        .a_i      (issue_a[g*w_lp +: w_lp]),
        .b_i      (issue_b[g*w_lp +: w_lp]),
        .req_o    (lane_req),
        .flags_o  (lane_flags[g]),
        .min_o    (lane_min[g*w_lp +: w_lp]),
        .max_o    (lane_max[g*w_lp +: w_lp])
      );
    end else begin : g_rest
      fpu_cmp_lane #(.e_p(e_p), .m_p(m_p)) i_lane (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (issue_req),
        .a_i      (issue_a[g*w_lp +: w_lp]),
        .b_i      (issue_b[g*w_lp +: w_lp]),
        .req_o    (),
        .flags_o  (lane_flags[g]),
        .min_o    (lane_min[g*w_lp +: w_lp]),
        .max_o    (lane_max[g*w_lp +: w_lp])
      );
    end
  end

  fpu_cmp_collect #(.lanes_p(lanes_p), .e_p(e_p), .m_p(m_p)) i_collect (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (lane_req),
    .flags_i       (lane_flags),
    .min_i         (lane_min),
    .max_i         (lane_max),
    .valid_o       (valid_o),
    .res_o         (res_o),
    .invalid_o     (invalid_o),
    .invalid_any_o (invalid_any_o)
  );

endmodule

//--- verif/fpu_vec_cmp_tb.sv
`timescale 1ns/1ns

module fpu_vec_cmp_tb;

  localparam int lanes_lp = 4;
  localparam int w_lp = 32;
  localparam logic [31:0] qnan_lp = 32'h7fc0_0000;

  // one expected output word set with the cycle it is due
  typedef struct packed {
    fpu_cmp_pkg::cmp_op_e  op;
    logic [lanes_lp*w_lp-1:0] res;
    logic [lanes_lp-1:0]      inv;
    logic [31:0]              due;
  } expect_s;

  logic clk;
  logic arst_n;
  logic valid_i;
  fpu_cmp_pkg::cmp_op_e op_i;
  logic [lanes_lp*w_lp-1:0] a_i;
  logic [lanes_lp*w_lp-1:0] b_i;
  logic valid_o;
  logic [lanes_lp*w_lp-1:0] res_o;
  logic [lanes_lp-1:0] invalid_o;
  logic invalid_any_o;

  expect_s exp_q[$];
  logic [15:0] lfsr_q = 16'd22353;
  logic [31:0] neg_cyc = 32'd0;
  int mismatch_cnt = 0;
  int fail_cnt = 0;

  fpu_vec_cmp i_fpu_vec_cmp (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .valid_i       (valid_i),
    .op_i          (op_i),
    .a_i           (a_i),
    .b_i           (b_i),
    .valid_o       (valid_o),
    .res_o         (res_o),
    .invalid_o     (invalid_o),
    .invalid_any_o (invalid_any_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // 16 bit fibonacci lfsr with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // class pick keeps zeros, infinities and NaNs frequent
  function automatic logic [31:0] make_operand(input logic [31:0] other);
    logic [31:0] r;
    logic [2:0] cls;
    logic sgn;
    logic [7:0] ex;
    logic [22:0] man;
    r = take_bits(3);
    cls = r[2:0];
    r = take_bits(1);
    sgn = r[0];
    r = take_bits(8);
    ex = r[7:0];
    r = take_bits(23);
    man = r[22:0];
    case (cls)
      3'd0: return {sgn, 31'h0};
      3'd1: return {sgn, 8'hff, 23'h0};
      3'd2: return {sgn, 8'hff, 1'b1, man[21:0]};
      // payload forced nonzero so it stays a NaN
      3'd3: return {sgn, 8'hff, 1'b0, man[21:1], 1'b1};
      3'd7: return other;
      default: begin
        if (ex == 8'hff) begin
          ex = 8'hfe;
        end
        return {sgn, ex, man};
      end
    endcase
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // signed ordering key where both zeros map to 0
  function automatic int order_key(input logic [31:0] x);
    int mag;
    mag = int'({1'b0, x[30:0]});
    return x[31] ? -mag : mag;
  endfunction

  function automatic void model_lane(input fpu_cmp_pkg::cmp_op_e op, input logic [31:0] a,
                                     input logic [31:0] b, output logic [31:0] res,
                                     output logic inv);
    logic any_nan;
    logic any_snan;
    int ka;
    int kb;
    any_nan = is_nan(a) | is_nan(b);
    any_snan = is_snan(a) | is_snan(b);
    ka = order_key(a);
    kb = order_key(b);
    res = '0;
    inv = 1'b0;
    case (op)
      fpu_cmp_pkg::OP_EQ: begin
        inv = any_snan;
        res[0] = !any_nan && (ka == kb);
      end
      fpu_cmp_pkg::OP_LT: begin
        inv = any_nan;
        res[0] = !any_nan && (ka < kb);
      end
      fpu_cmp_pkg::OP_LE: begin
        inv = any_nan;
        res[0] = !any_nan && (ka <= kb);
      end
      default: begin
        inv = any_snan;
        if (any_snan || (is_nan(a) && is_nan(b))) begin
          res = qnan_lp;
        end else if (is_nan(a)) begin
          res = b;
        end else if (is_nan(b)) begin
          res = a;
        end else if (ka == kb) begin
          res = (ka == 0) ? 32'h0 : a;
        end else if ((ka < kb) == (op == fpu_cmp_pkg::OP_MIN)) begin
          res = a;
        end else begin
          res = b;
        end
      end
    endcase
  endfunction

  // outputs sampled on the falling edge
  initial begin : monitor
    expect_s e;
    forever begin
      @(negedge clk);
      neg_cyc = neg_cyc + 32'd1;
      if (invalid_any_o !== (|invalid_o)) begin
        $display("Mismatch at %0t: invalid_any_o %b vs invalid_o %b", $time, invalid_any_o,
                 invalid_o);
        mismatch_cnt++;
      end
      if (valid_o !== 1'b1) begin
        if (invalid_o !== 4'h0 || invalid_any_o !== 1'b0) begin
          $display("Mismatch at %0t: invalid flags set without valid_o", $time);
          mismatch_cnt++;
        end
        if (exp_q.size() > 0 && exp_q[0].due <= neg_cyc) begin
          $display("Error at %0t: valid_o did not come 3 cycles after the request", $time);
          fail_cnt++;
          void'(exp_q.pop_front());
        end
      end else if (exp_q.size() == 0) begin
        $display("Error at %0t: valid_o came with no request outstanding", $time);
        fail_cnt++;
      end else begin
        e = exp_q.pop_front();
        if (e.due != neg_cyc) begin
          $display("Error at %0t: valid_o came at cycle %0d instead of %0d", $time, neg_cyc,
                   e.due);
          fail_cnt++;
        end
        for (int k = 0; k < lanes_lp; k++) begin
          if (res_o[k*w_lp +: w_lp] !== e.res[k*w_lp +: w_lp] || invalid_o[k] !== e.inv[k]) begin
            $display("Mismatch at %0t: lane %0d %s got %h/%b, expected %h/%b", $time, k,
                     e.op.name(), res_o[k*w_lp +: w_lp], invalid_o[k], e.res[k*w_lp +: w_lp],
                     e.inv[k]);
            mismatch_cnt++;
          end
        end
      end
    end
  end

  initial begin : driver
    expect_s e;
    fpu_cmp_pkg::cmp_op_e op;
    logic [31:0] r;
    logic [31:0] av;
    logic [31:0] bv;
    logic [31:0] lres;
    logic linv;
    logic [lanes_lp*w_lp-1:0] a_vec;
    logic [lanes_lp*w_lp-1:0] b_vec;
    int timeout;
    arst_n <= 1'b0;
    valid_i <= 1'b0;
    op_i <= fpu_cmp_pkg::OP_EQ;
    a_i <= '0;
    b_i <= '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    // idle stretch with quiet outputs
    repeat (4) @(posedge clk);
    for (int n = 0; n < 400; n++) begin
      @(posedge clk);
      r = take_bits(2);
      if (r[1:0] != 2'b00) begin
        r = take_bits(3);
        op = (r[2:0] > 3'd4) ? fpu_cmp_pkg::cmp_op_e'(r[2:0] - 3'd3)
                             : fpu_cmp_pkg::cmp_op_e'(r[2:0]);
        e = '0;
        for (int k = 0; k < lanes_lp; k++) begin
          av = make_operand(32'h3f80_0000);
          bv = make_operand(av);
          model_lane(op, av, bv, lres, linv);
          a_vec[k*w_lp +: w_lp] = av;
          b_vec[k*w_lp +: w_lp] = bv;
          e.res[k*w_lp +: w_lp] = lres;
          e.inv[k] = linv;
        end
        e.op = op;
        e.due = neg_cyc + 32'd4;
        exp_q.push_back(e);
        valid_i <= 1'b1;
        op_i <= op;
        a_i <= a_vec;
        b_i <= b_vec;
      end else begin
        valid_i <= 1'b0;
      end
    end
    @(posedge clk);
    valid_i <= 1'b0;
    timeout = 0;
    while (exp_q.size() != 0 && timeout < 20) begin
      @(posedge clk);
      timeout++;
    end
    if (exp_q.size() != 0) begin
      $display("Error: %0d results still pending when the drain wait timed out", exp_q.size());
      timeout = -1;
    end
    repeat (3) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt,
             fail_cnt + ((timeout < 0) ? 1 : 0));
    if (mismatch_cnt == 0 && fail_cnt == 0 && timeout >= 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- fpu_vec_cmp.f
hdl/fpu_cmp_pkg.sv
hdl/fpu_classify.sv
hdl/fpu_cmp_issue.sv
hdl/fpu_cmp_lane.sv
hdl/fpu_cmp_collect.sv
hdl/fpu_vec_cmp.sv
verif/fpu_vec_cmp_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the compare unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fpu_vec_cmp_tb -f fpu_vec_cmp.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vfpu_vec_cmp_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1
